// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_debugger
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== cpu_debugger.sv ====
`timescale 1ns/1ps

module cpu_debugger (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_uart_rx,
    output logic                   o_uart_tx,
    input  dbg_pkg::cpu_snapshot_t i_snapshot,
    output dbg_pkg::imem_wr_t      o_imem_wr,
    output logic                   o_mode,
    output logic                   o_step,
    output logic                   o_prog_reset
);
    import uart_pkg::*;
    import dbg_pkg::*;

    uart_rx_t   rx;
    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_busy;
    logic       cmd_valid;
    dbg_cmd_e   cmd;

    uart_link u_link (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_uart_rx  (i_uart_rx),
        .o_uart_tx  (o_uart_tx),
        .o_rx       (rx),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_tx_busy  (tx_busy)
    );

    dbg_cmd_ctrl u_cmd (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx         (rx),
        .i_snapshot   (i_snapshot),
        .o_tx_start   (tx_start),
        .o_tx_data    (tx_data),
        .i_tx_busy    (tx_busy),
        .o_cmd_valid  (cmd_valid),
        .o_cmd        (cmd),
        .o_imem_wr    (o_imem_wr),
        .o_prog_reset (o_prog_reset)
    );

    dbg_mode_ctrl u_mode (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_cmd_valid (cmd_valid),
        .i_cmd       (cmd),
        .o_mode      (o_mode),
        .o_step      (o_step)
    );

endmodule

// ==== dbg_cmd_ctrl.sv ====
`timescale 1ns/1ps
`include "dbg_config.svh"

module dbg_cmd_ctrl (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  uart_pkg::uart_rx_t     i_rx,
    input  dbg_pkg::cpu_snapshot_t i_snapshot,
    output logic                   o_tx_start,
    output uart_pkg::uart_byte_t   o_tx_data,
    input  logic                   i_tx_busy,
    output logic                   o_cmd_valid,
    output dbg_pkg::dbg_cmd_e      o_cmd,
    output dbg_pkg::imem_wr_t      o_imem_wr,
    output logic                   o_prog_reset
);
    import dbg_pkg::*;

    localparam int SNAP_W     = $bits(cpu_snapshot_t);
    localparam int REG_BYTES  = `DBG_NUM_REGS * `DBG_WORD_W / 8;
    localparam int IFID_BYTES = `DBG_IF_ID_W / 8;
    localparam int PC_BYTES   = `DBG_WORD_W / 8;
    localparam int IDX_W      = $clog2(SNAP_W / 8 + 1);
    localparam int RST_W      = $clog2(`DBG_PROG_RESET_CYCLES);

    dbg_state_e             state;
    logic [IDX_W-1:0]       byte_idx;     // Byte offset into the snapshot
    logic [IDX_W-1:0]       bytes_left;
    logic [7:0]             words_left;
    logic [1:0]             byte_cnt;     // Byte position inside a word
    logic [RST_W-1:0]       rst_cnt;
    logic [`DBG_WORD_W-1:0] word_buf;
    logic                   wr_stb;
    logic [`DBG_IMEM_AW-1:0] wr_addr;
    logic [SNAP_W-1:0]      snap_bits;

    assign snap_bits    = i_snapshot;
    assign o_cmd        = dbg_cmd_e'(i_rx.data);
    assign o_cmd_valid  = i_rx.valid && (state == IDLE);
    assign o_tx_start   = (state == SEND_BYTE) || (state == SEND_ACK);
    assign o_tx_data    = (state == SEND_ACK) ? ACK_BYTE
                                              : snap_bits[{byte_idx, 3'b000} +: 8];
    assign o_prog_reset = (state == PROG_RESET);
    assign o_imem_wr    = '{wr: wr_stb, addr: wr_addr, data: word_buf};

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state      <= IDLE;
            byte_idx   <= '0;
            bytes_left <= '0;
            words_left <= '0;
            byte_cnt   <= '0;
            rst_cnt    <= '0;
            wr_stb     <= 1'b0;
            wr_addr    <= '0;
        end else begin
            wr_stb <= 1'b0;
            if (wr_stb) wr_addr <= wr_addr + 1'b1;      // Advance after each write
            case (state)
                IDLE: if (i_rx.valid) begin
                    case (o_cmd)
                        CMD_DUMP_REGS: begin
                            byte_idx   <= '0;
                            bytes_left <= IDX_W'(REG_BYTES);
                            state      <= SEND_BYTE;
                        end
                        CMD_DUMP_IF_ID: begin
                            byte_idx   <= IDX_W'(REG_BYTES);
                            bytes_left <= IDX_W'(IFID_BYTES);
                            state      <= SEND_BYTE;
                        end
                        CMD_DUMP_PC: begin
                            byte_idx   <= IDX_W'(REG_BYTES + IFID_BYTES);
                            bytes_left <= IDX_W'(PC_BYTES);
                            state      <= SEND_BYTE;
                        end
                        CMD_LOAD_PROG: begin
                            wr_addr <= '0;
                            state   <= GET_COUNT;
                        end
                        default: state <= IDLE;           // Mode commands and unknown bytes
                    endcase
                end
                SEND_BYTE: state <= WAIT_TX;
                WAIT_TX: if (!i_tx_busy) begin
                    if (bytes_left == IDX_W'(1)) begin
                        state <= SEND_ACK;
                    end else begin
                        byte_idx   <= byte_idx + 1'b1;
                        bytes_left <= bytes_left - 1'b1;
                        state      <= SEND_BYTE;
                    end
                end
                SEND_ACK: state <= WAIT_ACK;
                WAIT_ACK: if (!i_tx_busy) state <= IDLE;
                GET_COUNT: if (i_rx.valid) begin
                    words_left <= i_rx.data;
                    byte_cnt   <= '0;
                    rst_cnt    <= '0;
                    state      <= (i_rx.data == 8'd0) ? PROG_RESET : GET_WORD;
                end
                GET_WORD: if (i_rx.valid) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'd3) begin
                        wr_stb     <= 1'b1;
                        words_left <= words_left - 1'b1;
                        if (words_left == 8'd1) state <= PROG_RESET;
                    end
                end
                PROG_RESET: begin
                    rst_cnt <= rst_cnt + 1'b1;
                    if (rst_cnt == RST_W'(`DBG_PROG_RESET_CYCLES - 1)) state <= SEND_ACK;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Little-endian assembly, the first byte ends up in bits 7:0
    always_ff @(posedge i_clk) begin
        if (state == GET_WORD && i_rx.valid) begin
            word_buf <= {i_rx.data, word_buf[`DBG_WORD_W-1:8]};
        end
    end

endmodule

// ==== dbg_config.svh ====
`ifndef DBG_CONFIG_SVH
`define DBG_CONFIG_SVH

// Oversampling tick divider, set to 261 for the board clock
`define DBG_CLKS_PER_TICK      4
`define DBG_TICKS_PER_BIT      16    // Ticks in one serial bit

`define DBG_NUM_REGS           8     // Registers in the dump
`define DBG_WORD_W             32    // Processor word width
`define DBG_IF_ID_W            64    // IF/ID latch width

`define DBG_IMEM_AW            6     // Instruction memory address width

// Cycles the processor is held in reset after a load
`define DBG_PROG_RESET_CYCLES  16

`endif

// ==== dbg_mode_ctrl.sv ====
`timescale 1ns/1ps

module dbg_mode_ctrl (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_cmd_valid,
    input  dbg_pkg::dbg_cmd_e i_cmd,
    output logic              o_mode,
    output logic              o_step
);
    import dbg_pkg::*;

    // o_mode: 0 runs freely, 1 advances only on step pulses
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_mode <= 1'b0;
            o_step <= 1'b0;
        end else begin
            o_step <= 1'b0;                       // Pulse lasts one clock
            if (i_cmd_valid) begin
                case (i_cmd)
                    CMD_RUN: begin
                        o_mode <= 1'b0;
                    end
                    CMD_DEBUG,
                    CMD_LOAD_PROG: begin
                        o_mode <= 1'b1;           // Loading halts the core too
                    end
                    CMD_STEP: begin
                        o_step <= o_mode;         // No step in run mode
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== dbg_pkg.sv ====
`include "dbg_config.svh"

package dbg_pkg;

    // Host command opcodes
    typedef enum logic [7:0] {
        CMD_DUMP_REGS  = 8'h01,
        CMD_DUMP_IF_ID = 8'h02,
        CMD_LOAD_PROG  = 8'h07,
        CMD_RUN        = 8'h08,
        CMD_DEBUG      = 8'h09,
        CMD_STEP       = 8'h0A,
        CMD_DUMP_PC    = 8'h11
    } dbg_cmd_e;

    typedef enum logic [3:0] {
        IDLE,
        SEND_BYTE,
        WAIT_TX,
        SEND_ACK,
        WAIT_ACK,
        GET_COUNT,
        GET_WORD,
        PROG_RESET
    } dbg_state_e;

    // Register 0 sits in the lowest word, the PC at the top
    typedef struct packed {
        logic [`DBG_WORD_W-1:0]                 pc;
        logic [`DBG_IF_ID_W-1:0]                if_id;
        logic [`DBG_NUM_REGS*`DBG_WORD_W-1:0]   regs;
    } cpu_snapshot_t;

    typedef struct packed {
        logic                    wr;      // One cycle per completed word
        logic [`DBG_IMEM_AW-1:0] addr;
        logic [`DBG_WORD_W-1:0]  data;
    } imem_wr_t;

    localparam logic [7:0] ACK_BYTE = 8'h52;    // ASCII 'R'

endpackage

// ==== sim.f ====
+incdir+.
uart_pkg.sv
dbg_pkg.sv
uart_rx.sv
uart_tx.sv
uart_link.sv
dbg_mode_ctrl.sv
dbg_cmd_ctrl.sv
cpu_debugger.sv
tb_cpu_debugger.sv

// ==== tb_cpu_debugger.sv ====
`timescale 1ns/1ps
`include "dbg_config.svh"

module tb_cpu_debugger;
    import uart_pkg::*;
    import dbg_pkg::*;

    localparam int CLK_HALF    = 4;                          // 8 ns period
    localparam int RESET_CLKS  = 3;
    localparam int BIT_CLKS    = `DBG_CLKS_PER_TICK * `DBG_TICKS_PER_BIT;
    localparam int SETTLE_CLKS = 4 * BIT_CLKS;               // Quiet time after each reply
    localparam int SNAP_W      = $bits(cpu_snapshot_t);
    localparam int NUM_ROWS    = 12;

    typedef enum logic [1:0] {KIND_DUMP, KIND_LOAD, KIND_MODE, KIND_QUIET} kind_e;

    typedef struct packed {
        logic [7:0]   cmd;
        int           n_send;       // Payload bytes after the opcode
        logic [127:0] payload;      // Lowest byte goes out first
        int           n_reply;
        kind_e        kind;
        logic         exp_mode;
        int           exp_steps;
    } test_row_t;

    logic          i_clk;
    logic          i_reset;
    logic          i_uart_rx;
    logic          o_uart_tx;
    cpu_snapshot_t i_snapshot;
    imem_wr_t      o_imem_wr;
    logic          o_mode;
    logic          o_step;
    logic          o_prog_reset;

    test_row_t               table_rows [NUM_ROWS];
    logic                    table_ready;
    logic [7:0]              rx_q [$];
    logic [`DBG_IMEM_AW-1:0] wr_addr_q [$];
    logic [`DBG_WORD_W-1:0]  wr_data_q [$];
    int                      prst_q [$];
    int                      prst_len;
    int                      step_cnt;
    logic                    mon_busy;
    int                      mon_err_cnt;
    int                      err_cnt;
    int                      pass_cnt;
    int                      fail_cnt;

    cpu_debugger DUT (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_uart_rx    (i_uart_rx),
        .o_uart_tx    (o_uart_tx),
        .i_snapshot   (i_snapshot),
        .o_imem_wr    (o_imem_wr),
        .o_mode       (o_mode),
        .o_step       (o_step),
        .o_prog_reset (o_prog_reset)
    );

    initial begin
        i_clk = 1'b0;
        forever #CLK_HALF i_clk = ~i_clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int total_errors();
        return err_cnt + mon_err_cnt;
    endfunction

    // Reply byte idx of a row, the acknowledge always comes last
    function automatic logic [7:0] expected_byte(input logic [7:0] cmd, input int idx,
                                                 input int n_reply);
        if (idx == n_reply - 1) return ACK_BYTE;
        case (cmd)
            CMD_DUMP_REGS:  return i_snapshot.regs[idx*8 +: 8];
            CMD_DUMP_IF_ID: return i_snapshot.if_id[idx*8 +: 8];
            CMD_DUMP_PC:    return i_snapshot.pc[idx*8 +: 8];
            default:        return 8'h00;
        endcase
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error: %s", msg);
        err_cnt++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (total_errors() == errs_before) begin
            pass_cnt++;
            $display("Test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("Test %s: FAILED", name);
        end
    endtask

    task automatic fill_snapshot();
        logic [31:0]       lfsr;
        logic [SNAP_W-1:0] bits;
        lfsr = 32'h7aea49a7;
        for (int i = 0; i < SNAP_W; i++) begin
            lfsr    = lfsr_next(lfsr);                      // One step per bit
            bits[i] = lfsr[0];
        end
        i_snapshot = cpu_snapshot_t'(bits);
    endtask

    task automatic add_row(input int idx, input logic [7:0] cmd, input int n_send,
                           input logic [127:0] payload, input int n_reply, input kind_e kind,
                           input logic exp_mode, input int exp_steps);
        table_rows[idx] = '{cmd: cmd, n_send: n_send, payload: payload, n_reply: n_reply,
                            kind: kind, exp_mode: exp_mode, exp_steps: exp_steps};
    endtask

    task automatic build_table();
        add_row(0, CMD_DUMP_REGS, 0, '0, 33, KIND_DUMP, 1'b0, 0);
        add_row(1, CMD_DUMP_IF_ID, 0, '0, 9, KIND_DUMP, 1'b0, 0);
        add_row(2, CMD_DUMP_PC, 0, '0, 5, KIND_DUMP, 1'b0, 0);
        // Count of 3, then three words lowest byte first
        add_row(3, CMD_LOAD_PROG, 13,
                {24'h0, 32'h002081b3, 32'h00a00113, 32'h00500093, 8'h03},
                1, KIND_LOAD, 1'b1, 0);
        add_row(4, CMD_RUN, 0, '0, 0, KIND_MODE, 1'b0, 0);
        add_row(5, CMD_STEP, 0, '0, 0, KIND_MODE, 1'b0, 0);    // Ignored in run mode
        add_row(6, CMD_DEBUG, 0, '0, 0, KIND_MODE, 1'b1, 0);
        add_row(7, CMD_STEP, 0, '0, 0, KIND_MODE, 1'b1, 1);
        add_row(8, CMD_STEP, 0, '0, 0, KIND_MODE, 1'b1, 1);
        add_row(9, CMD_STEP, 0, '0, 0, KIND_MODE, 1'b1, 1);
        add_row(10, 8'h3C, 0, '0, 0, KIND_QUIET, 1'b1, 0);
        add_row(11, CMD_DUMP_PC, 0, '0, 5, KIND_DUMP, 1'b1, 0);
    endtask

    // Start bit, eight data bits LSB first, stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clk);
            i_uart_rx <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge i_clk);
        end
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = total_errors();
        if (o_mode !== 1'b0) report_value("o_mode", 32'(o_mode), 32'h0);
        if (o_step !== 1'b0) report_value("o_step", 32'(o_step), 32'h0);
        if (o_prog_reset !== 1'b0) report_value("o_prog_reset", 32'(o_prog_reset), 32'h0);
        if (o_uart_tx !== 1'b1) report_value("o_uart_tx", 32'(o_uart_tx), 32'h1);
        if (wr_addr_q.size() != 0) report_problem("a write strobe was seen after reset");
        finish_test("reset", errs_before);
    endtask

    task automatic run_row(input int r);
        test_row_t row;
        kind_e     kind;
        int        errs_before;
        int        rx_base;
        int        wr_base;
        int        prst_base;
        int        step_base;
        int        exp_writes;
        row         = table_rows[r];
        kind        = row.kind;
        errs_before = total_errors();
        rx_base     = rx_q.size();
        wr_base     = wr_addr_q.size();
        prst_base   = prst_q.size();
        step_base   = step_cnt;
        exp_writes  = (kind == KIND_LOAD) ? int'(row.payload[7:0]) : 0;

        send_byte(row.cmd);
        for (int k = 0; k < row.n_send; k++) send_byte(row.payload[8*k +: 8]);
        while (rx_q.size() - rx_base < row.n_reply) @(negedge i_clk);
        repeat (SETTLE_CLKS) @(negedge i_clk);

        if (rx_q.size() - rx_base != row.n_reply || mon_busy)
            report_problem($sformatf("expected %0d reply bytes, saw %0d or more",
                                     row.n_reply, rx_q.size() - rx_base));
        for (int k = 0; k < row.n_reply && rx_base + k < rx_q.size(); k++) begin
            if (rx_q[rx_base + k] !== expected_byte(row.cmd, k, row.n_reply))
                report_value($sformatf("o_uart_tx byte %0d", k), 32'(rx_q[rx_base + k]),
                             32'(expected_byte(row.cmd, k, row.n_reply)));
        end
        if (o_mode !== row.exp_mode) report_value("o_mode", 32'(o_mode), 32'(row.exp_mode));
        if (step_cnt - step_base != row.exp_steps)
            report_value("o_step cycles", 32'(step_cnt - step_base), 32'(row.exp_steps));
        if (wr_addr_q.size() - wr_base != exp_writes) begin
            report_value("o_imem_wr count", 32'(wr_addr_q.size() - wr_base), 32'(exp_writes));
        end else begin
            for (int k = 0; k < exp_writes; k++) begin
                if (wr_addr_q[wr_base + k] !== `DBG_IMEM_AW'(k))
                    report_value("o_imem_wr.addr", 32'(wr_addr_q[wr_base + k]), 32'(k));
                if (wr_data_q[wr_base + k] !== row.payload[8 + 32*k +: 32])
                    report_value("o_imem_wr.data", wr_data_q[wr_base + k],
                                 row.payload[8 + 32*k +: 32]);
            end
        end
        if (prst_q.size() - prst_base != ((kind == KIND_LOAD) ? 1 : 0))
            report_problem("wrong number of o_prog_reset pulses");
        else if (kind == KIND_LOAD && prst_q[prst_base] != `DBG_PROG_RESET_CYCLES)
            report_value("o_prog_reset length", 32'(prst_q[prst_base]),
                         32'(`DBG_PROG_RESET_CYCLES));
        finish_test($sformatf("%0d %s cmd 0x%h", r, kind.name(), row.cmd), errs_before);
    endtask

    // Serial monitor, samples at mid-bit on the falling edge
    initial begin
        logic [7:0] data;
        mon_busy    = 1'b0;
        mon_err_cnt = 0;
        forever begin
            @(negedge i_clk);
            if (i_reset === 1'b0 && o_uart_tx === 1'b0) begin
                mon_busy = 1'b1;
                repeat (BIT_CLKS / 2) @(negedge i_clk);
                if (o_uart_tx !== 1'b0) begin
                    $display("Error: start bit on o_uart_tx ended early");
                    mon_err_cnt++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge i_clk);
                    data[i] = o_uart_tx;
                end
                repeat (BIT_CLKS) @(negedge i_clk);
                if (o_uart_tx !== 1'b1) begin
                    $display("Error: stop bit missing on o_uart_tx");
                    mon_err_cnt++;
                end
                rx_q.push_back(data);
                mon_busy = 1'b0;
            end
        end
    end

    // Write strobes, step cycles and program-reset pulse lengths
    initial begin
        prst_len = 0;
        step_cnt = 0;
        forever begin
            @(negedge i_clk);
            if (o_imem_wr.wr === 1'b1) begin
                wr_addr_q.push_back(o_imem_wr.addr);
                wr_data_q.push_back(o_imem_wr.data);
            end
            if (o_step === 1'b1) step_cnt++;
            if (o_prog_reset === 1'b1) begin
                prst_len++;
            end else if (prst_len != 0) begin
                prst_q.push_back(prst_len);
                prst_len = 0;
            end
        end
    end

    // Twice the serial time of every row, plus reset
    initial begin
        int limit;
        wait (table_ready === 1'b1);
        limit = RESET_CLKS + 16;
        for (int r = 0; r < NUM_ROWS; r++)
            limit += (1 + table_rows[r].n_send + table_rows[r].n_reply) * 10 * BIT_CLKS * 2;
        repeat (limit) @(posedge i_clk);
        $display("Timeout: the DUT did not finish within %0d clock cycles", limit);
        $display("Regression failed");
        $finish;
    end

    initial begin
        i_reset   = 1'b1;
        i_uart_rx = 1'b1;                                   // Idle line
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        fill_snapshot();
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CLKS) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (4) @(negedge i_clk);
        check_reset();
        for (int r = 0; r < NUM_ROWS; r++) run_row(r);
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_cnt, fail_cnt, total_errors());
        if (fail_cnt == 0 && total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== uart_link.sv ====
`timescale 1ns/1ps
`include "dbg_config.svh"

module uart_link (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_uart_rx,
    output logic                 o_uart_tx,
    output uart_pkg::uart_rx_t   o_rx,
    input  logic                 i_tx_start,
    input  uart_pkg::uart_byte_t i_tx_data,
    output logic                 o_tx_busy
);
    localparam int DIV_W = $clog2(`DBG_CLKS_PER_TICK);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    // One tick every DBG_CLKS_PER_TICK clocks, shared by both directions
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick    <= (div_cnt == DIV_W'(`DBG_CLKS_PER_TICK - 1));
            div_cnt <= (div_cnt == DIV_W'(`DBG_CLKS_PER_TICK - 1)) ? '0 : div_cnt + 1'b1;
        end
    end

    uart_rx u_rx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_rx    (i_uart_rx),
        .o_rx    (o_rx)
    );

    uart_tx u_tx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_start (i_tx_start),
        .i_data  (i_tx_data),
        .o_busy  (o_tx_busy),
        .o_tx    (o_uart_tx)
    );

endmodule

// ==== uart_pkg.sv ====
package uart_pkg;

    // One byte on the serial line
    typedef logic [7:0] uart_byte_t;

    // Received byte with its single-cycle strobe
    typedef struct packed {
        logic       valid;    // High for one cycle per byte
        uart_byte_t data;     // Stable while valid is high
    } uart_rx_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`include "dbg_config.svh"

module uart_rx (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_tick,
    input  logic               i_rx,
    output uart_pkg::uart_rx_t o_rx
);
    import uart_pkg::*;

    localparam int TICK_W = $clog2(`DBG_TICKS_PER_BIT);
    localparam logic [TICK_W-1:0] HALF_BIT = TICK_W'(`DBG_TICKS_PER_BIT / 2 - 1);
    localparam logic [TICK_W-1:0] FULL_BIT = TICK_W'(`DBG_TICKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e         state;
    logic              rx_meta;
    logic              rx_sync;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    logic              rx_valid;
    uart_byte_t        rx_data;

    assign o_rx = '{valid: rx_valid, data: rx_data};

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            rx_meta  <= 1'b1;                   // Idle line is high
            rx_sync  <= 1'b1;
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= i_rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync) state <= RX_START;
                end
                RX_START: if (i_tick) begin
                    if (tick_cnt == HALF_BIT) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;    // Reject glitches
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;                   // Wraps at FULL_BIT
                    if (tick_cnt == FULL_BIT) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == FULL_BIT) begin
                        rx_valid <= rx_sync;            // Drop framing errors
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && i_tick && tick_cnt == FULL_BIT) rx_data <= {rx_sync, rx_data[7:1]};
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`include "dbg_config.svh"

module uart_tx (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  logic                 i_start,
    input  uart_pkg::uart_byte_t i_data,
    output logic                 o_busy,
    output logic                 o_tx
);
    import uart_pkg::*;

    localparam int TICK_W = $clog2(`DBG_TICKS_PER_BIT);
    localparam logic [TICK_W-1:0] FULL_BIT = TICK_W'(`DBG_TICKS_PER_BIT - 1);

    typedef enum logic [2:0] {TX_IDLE, TX_ARM, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    logic              bit_end;
    uart_byte_t        shift;

    assign o_busy  = (state != TX_IDLE);
    assign bit_end = i_tick && (tick_cnt == FULL_BIT);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_tx     <= 1'b1;
        end else begin
            if (i_tick) tick_cnt <= tick_cnt + 1'b1;
            case (state)
                TX_IDLE: if (i_start) state <= TX_ARM;
                TX_ARM: if (i_tick) begin                   // Align start bit to a tick
                    o_tx     <= 1'b0;
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    state    <= TX_START;
                end
                TX_START: if (bit_end) begin
                    o_tx  <= shift[0];
                    state <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    o_tx    <= (bit_cnt == 3'd7) ? 1'b1 : shift[0];
                    if (bit_cnt == 3'd7) state <= TX_STOP;
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_start) shift <= i_data;
        else if ((state == TX_START || state == TX_DATA) && bit_end) shift <= shift >> 1;
    end

endmodule
